// File: design/nnLayer_config.svh
`ifndef NN_LAYER_CONFIG_SVH
`define NN_LAYER_CONFIG_SVH

// layer shape.
`define NN_NUM_INPUTS 15
`define NN_NUM_NODES 4

// fixed-point widths.
`define NN_DATA_WIDTH 8
`define NN_WEIGHT_WIDTH 8
`define NN_BIAS_WIDTH 16
`define NN_ACC_WIDTH 23

// output scaling, the sum keeps 6 fraction bits.
`define NN_FRAC_SHIFT 6
`define NN_SAT_MAX 127

// configuration address, node in the high field and slot in the low field.
`define NN_NODE_SEL_WIDTH 2
`define NN_SLOT_WIDTH 4

// the last slot of a node holds its bias.
`define NN_BIAS_SLOT 15

`endif

// File: design/nnLayerPkg.sv
`include "nnLayer_config.svh"

package nnLayerPkg;

	// signed fixed-point data types.
	typedef logic signed [`NN_DATA_WIDTH-1:0] activation_t;

	typedef logic signed [`NN_WEIGHT_WIDTH-1:0] weight_t;

	typedef logic signed [`NN_BIAS_WIDTH-1:0] bias_t;

	typedef logic signed [`NN_ACC_WIDTH-1:0] acc_t;

	// node select in the upper bits, slot select in the lower bits.
	typedef logic [`NN_NODE_SEL_WIDTH+`NN_SLOT_WIDTH-1:0] cfgAddr_t;

	// a configuration word is either a full bias or a weight in the low byte.
	typedef union packed
	{
		bias_t bias;
		struct packed
		{
			logic [`NN_BIAS_WIDTH-`NN_WEIGHT_WIDTH-1:0] reserved;
			weight_t weight;
		} weightWord;
	} cfgWord_u;

endpackage

// File: design/layerWeightRegs.sv
`timescale 1ns/100ps
`include "nnLayer_config.svh"

module layerWeightRegs
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input nnLayerPkg::cfgAddr_t cfgAddr,
	input nnLayerPkg::cfgWord_u cfgData,
	output nnLayerPkg::weight_t weights [`NN_NUM_NODES][`NN_NUM_INPUTS],
	output nnLayerPkg::bias_t biases [`NN_NUM_NODES]
);

	import nnLayerPkg::*;

	logic [`NN_NODE_SEL_WIDTH-1:0] wrNode;
	logic [`NN_SLOT_WIDTH-1:0] wrSlot;
	logic biasSel;
	logic [`NN_NUM_NODES-1:0] nodeSel;
	logic [`NN_NUM_INPUTS-1:0] slotSel;
	weight_t wrWeight;
	bias_t wrBias;

	// split the address into its node and slot fields.
	assign wrNode = cfgAddr[`NN_NODE_SEL_WIDTH+`NN_SLOT_WIDTH-1:`NN_SLOT_WIDTH];
	assign wrSlot = cfgAddr[`NN_SLOT_WIDTH-1:0];

	assign biasSel = (wrSlot == `NN_SLOT_WIDTH'(`NN_BIAS_SLOT));

	// the same data word read through both views.
	assign wrWeight = cfgData.weightWord.weight;
	assign wrBias = cfgData.bias;

	// one-hot node enable, qualified by the write strobe.
	always_comb
	begin
		for (int n = 0; n < `NN_NUM_NODES; n++)
		begin
			nodeSel[n] = cfgWrite && (int'(wrNode) == n);
		end
	end

	// one-hot weight slot, never set for the bias slot.
	always_comb
	begin
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			slotSel[s] = (int'(wrSlot) == s);
		end
	end

	// per-node storage.
	// a write at edge k is visible on the outputs right after edge k.
	for (genvar n = 0; n < `NN_NUM_NODES; n++)
	begin : gNodeRegs
		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				biases[n] <= '0;
			end
			else if (nodeSel[n] && biasSel)
			begin
				biases[n] <= wrBias;
			end
		end

		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				for (int s = 0; s < `NN_NUM_INPUTS; s++)
				begin
					weights[n][s] <= '0;
				end
			end
			else if (nodeSel[n])
			begin
				for (int s = 0; s < `NN_NUM_INPUTS; s++)
				begin
					if (slotSel[s])
					begin
						weights[n][s] <= wrWeight;
					end
				end
			end
		end
	end

endmodule

// File: design/neuronNode.sv
`timescale 1ns/100ps
`include "nnLayer_config.svh"

module neuronNode
(
	input logic clk,
	input logic reset,
	input nnLayerPkg::activation_t activations [`NN_NUM_INPUTS],
	input nnLayerPkg::weight_t weights [`NN_NUM_INPUTS],
	input nnLayerPkg::bias_t bias,
	output nnLayerPkg::activation_t result
);

	import nnLayerPkg::*;

	// full product width of one activation times one weight.
	localparam int ProdWidth = `NN_DATA_WIDTH + `NN_WEIGHT_WIDTH;

	// integer part of the sum plus one bit of headroom for the round increment.
	localparam int ShiftWidth = `NN_ACC_WIDTH - `NN_FRAC_SHIFT;
	localparam int RoundWidth = ShiftWidth + 1;

	activation_t actReg [`NN_NUM_INPUTS];
	logic signed [ProdWidth-1:0] products [`NN_NUM_INPUTS];
	acc_t sumNext;
	acc_t sumReg;

	logic sumNegative;
	logic [ShiftWidth-1:0] shifted;
	logic roundBit;
	logic [RoundWidth-1:0] rounded;
	activation_t resultNext;

	// stage 1, capture the input vector.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
			begin
				actReg[i] <= '0;
			end
		end
		else
		begin
			for (int i = 0; i < `NN_NUM_INPUTS; i++)
			begin
				actReg[i] <= activations[i];
			end
		end
	end

	// signed 8x8 products against the current weights.
	always_comb
	begin
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			products[i] = actReg[i] * weights[i];
		end
	end

	// adder tree, everything sign-extended to the accumulator width.
	always_comb
	begin
		sumNext = acc_t'(bias);
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			sumNext = sumNext + acc_t'(products[i]);
		end
	end

	// stage 2, the accumulated sum.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			sumReg <= '0;
		end
		else
		begin
			sumReg <= sumNext;
		end
	end

	assign sumNegative = sumReg[`NN_ACC_WIDTH-1];

	// drop the fraction, the first dropped bit decides the round up.
	assign shifted = sumReg[`NN_ACC_WIDTH-1:`NN_FRAC_SHIFT];
	assign roundBit = sumReg[`NN_FRAC_SHIFT-1];
	assign rounded = {1'b0, shifted} + RoundWidth'(roundBit);

	// rectifier and clamp.
	// only meaningful for a non-negative sum, so rounded is treated as unsigned.
	always_comb
	begin
		if (sumNegative)
		begin
			resultNext = '0;
		end
		else if (rounded > RoundWidth'(`NN_SAT_MAX))
		begin
			resultNext = activation_t'(`NN_SAT_MAX);
		end
		else
		begin
			resultNext = rounded[`NN_DATA_WIDTH-1:0];
		end
	end

	// stage 3, the output activation.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else
		begin
			result <= resultNext;
		end
	end

endmodule

// File: design/nnLayer.sv
`timescale 1ns/100ps
`include "nnLayer_config.svh"

module nnLayer
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input nnLayerPkg::cfgAddr_t cfgAddr,
	input nnLayerPkg::cfgWord_u cfgData,
	input nnLayerPkg::activation_t activations [`NN_NUM_INPUTS],
	output nnLayerPkg::activation_t results [`NN_NUM_NODES]
);

	import nnLayerPkg::*;

	weight_t nodeWeights [`NN_NUM_NODES][`NN_NUM_INPUTS];
	bias_t nodeBiases [`NN_NUM_NODES];

	layerWeightRegs i_weightRegs
	(
		.clk (clk),
		.reset (reset),
		.cfgWrite (cfgWrite),
		.cfgAddr (cfgAddr),
		.cfgData (cfgData),
		.weights (nodeWeights),
		.biases (nodeBiases)
	);

	// every neuron sees the same input vector with its own weights and bias.
	for (genvar n = 0; n < `NN_NUM_NODES; n++)
	begin : gNeuron
		neuronNode i_neuron
		(
			.clk (clk),
			.reset (reset),
			.activations (activations),
			.weights (nodeWeights[n]),
			.bias (nodeBiases[n]),
			.result (results[n])
		);
	end

endmodule

// File: tb/nnLayer_checker.sv
`timescale 1ns/100ps
`include "nnLayer_config.svh"

module nnLayer_checker
(
	input logic clk,
	input logic reset,
	input nnLayerPkg::activation_t results [`NN_NUM_NODES],
	input logic [`NN_NUM_NODES-1:0] sumNegative
);

	import nnLayerPkg::*;

	// read by the testbench at the end of the run.
	int assertFails = 0;

	for (genvar n = 0; n < `NN_NUM_NODES; n++)
	begin : gNodeChecks
		// the output register clears one cycle after reset is seen.
		resetClears : assert property (@(posedge clk) reset |=> (results[n] == '0))
		else
		begin
			assertFails++;
			$error("result %0d not zero after reset", n);
		end

		// rectified and saturated, so always within 0 to 127.
		resultInRange : assert property (@(posedge clk) disable iff (reset)
			($unsigned(results[n]) <= `NN_SAT_MAX))
		else
		begin
			assertFails++;
			$error("result %0d out of range: %0d", n, results[n]);
		end

		// a negative sum becomes a zero output one stage later.
		negativeGivesZero : assert property (@(posedge clk) disable iff (reset)
			sumNegative[n] |=> (results[n] == '0))
		else
		begin
			assertFails++;
			$error("result %0d not zero after a negative sum", n);
		end
	end

endmodule

// File: tb/nnLayerTb.sv
`timescale 1ns/100ps
`include "nnLayer_config.svh"

module nnLayerTb;

	import nnLayerPkg::*;

	localparam int Latency = 3;
	localparam int ResetCycles = 10;
	localparam int RandomVectors = 40;
	localparam int LoadCycles = `NN_NUM_NODES * (`NN_NUM_INPUTS + 1);
	// the tests write a full layer twice, stream the vectors and drain about a dozen times.
	localparam int TimeoutCycles = ResetCycles + 2 * LoadCycles + RandomVectors
		+ 12 * Latency + 100;

	logic clk;
	logic reset;
	logic cfgWrite;
	cfgAddr_t cfgAddr;
	cfgWord_u cfgData;
	activation_t activations [`NN_NUM_INPUTS];
	activation_t results [`NN_NUM_NODES];

	int seed = 35560;
	int errorCount = 0;
	int cycleCount = 0;

	// own copy of the configuration, and the vector being driven.
	int modelWeight [`NN_NUM_NODES][`NN_NUM_INPUTS];
	int modelBias [`NN_NUM_NODES];
	activation_t stimVec [`NN_NUM_INPUTS];

	// expected results in flight, each with the cycle it is due in.
	int dueQueue [$];
	logic [`NN_NUM_NODES*`NN_DATA_WIDTH-1:0] expQueue [$];

	nnLayer i_dut
	(
		.clk (clk),
		.reset (reset),
		.cfgWrite (cfgWrite),
		.cfgAddr (cfgAddr),
		.cfgData (cfgData),
		.activations (activations),
		.results (results)
	);

	bind nnLayer nnLayer_checker i_checker
	(
		.clk (clk),
		.reset (reset),
		.results (results),
		.sumNegative ({gNeuron[3].i_neuron.sumNegative, gNeuron[2].i_neuron.sumNegative,
			gNeuron[1].i_neuron.sumNegative, gNeuron[0].i_neuron.sumNegative})
	);

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleCount > TimeoutCycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// bias plus weighted sum, then rectify, round half up and clamp.
	function automatic activation_t modelNeuron(input int node);
		int sum;
		int scaled;
		sum = modelBias[node];
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			sum += int'(stimVec[i]) * modelWeight[node][i];
		end
		if (sum < 0)
		begin
			return '0;
		end
		scaled = (sum >> `NN_FRAC_SHIFT) + ((sum >> (`NN_FRAC_SHIFT - 1)) & 1);
		if (scaled > `NN_SAT_MAX)
		begin
			scaled = `NN_SAT_MAX;
		end
		return activation_t'(scaled);
	endfunction

	task automatic checkResult(input string name, input activation_t expected,
		input activation_t actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("MISMATCH at %0t ns: %s expected %0d, got %0d", $time, name,
				expected, actual);
		end
	endtask

	task automatic checkDue();
		logic [`NN_NUM_NODES*`NN_DATA_WIDTH-1:0] expWord;
		while (dueQueue.size() > 0 && dueQueue[0] == cycleCount)
		begin
			void'(dueQueue.pop_front());
			expWord = expQueue.pop_front();
			for (int n = 0; n < `NN_NUM_NODES; n++)
			begin
				checkResult($sformatf("results[%0d]", n),
					expWord[n*`NN_DATA_WIDTH +: `NN_DATA_WIDTH], results[n]);
			end
		end
	endtask

	// one cycle of stimulus, optionally with a configuration write.
	// a write in the same cycle as a vector already applies to that vector.
	task automatic runCycle(input bit doWrite, input int node, input int slot,
		input int value);
		logic [`NN_NUM_NODES*`NN_DATA_WIDTH-1:0] expWord;
		cfgWord_u word;
		@(posedge clk);
		#2;
		checkDue();
		word = '0;
		if (slot == `NN_BIAS_SLOT)
		begin
			word.bias = bias_t'(value);
		end
		else
		begin
			// high byte is don't care for a weight.
			word.weightWord.reserved = '1;
			word.weightWord.weight = weight_t'(value);
		end
		cfgWrite = doWrite;
		cfgAddr = cfgAddr_t'((node << `NN_SLOT_WIDTH) | slot);
		cfgData = word;
		activations = stimVec;
		if (doWrite && slot == `NN_BIAS_SLOT)
		begin
			modelBias[node] = int'(bias_t'(value));
		end
		else if (doWrite)
		begin
			modelWeight[node][slot] = int'(weight_t'(value));
		end
		for (int n = 0; n < `NN_NUM_NODES; n++)
		begin
			expWord[n*`NN_DATA_WIDTH +: `NN_DATA_WIDTH] = modelNeuron(n);
		end
		dueQueue.push_back(cycleCount + Latency);
		expQueue.push_back(expWord);
	endtask

	task automatic idleCycle();
		runCycle(1'b0, 0, 0, 0);
	endtask

	task automatic drainPipe();
		while (dueQueue.size() > 0)
		begin
			@(posedge clk);
			#2;
			checkDue();
			cfgWrite = 1'b0;
		end
	endtask

	task automatic writeNode(input int node, input weight_t w [`NN_NUM_INPUTS],
		input bias_t b);
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			runCycle(1'b1, node, s, int'(w[s]));
		end
		runCycle(1'b1, node, `NN_BIAS_SLOT, int'(b));
	endtask

	task automatic testReset();
		for (int n = 0; n < `NN_NUM_NODES; n++)
		begin
			checkResult($sformatf("results[%0d]", n), '0, results[n]);
		end
		idleCycle();
		drainPipe();
	endtask

	task automatic testReferenceLoad();
		weight_t refWeights [`NN_NUM_INPUTS] = '{12, -7, 25, 3, -18, 9, 0, 31, -4, 15,
			-22, 6, 11, -9, 20};
		weight_t otherWeights [`NN_NUM_INPUTS];
		writeNode(0, refWeights, 16'sd512);
		for (int n = 1; n < `NN_NUM_NODES; n++)
		begin
			for (int s = 0; s < `NN_NUM_INPUTS; s++)
			begin
				otherWeights[s] = weight_t'((s * 13 + n * 7) % 41 - 20);
			end
			writeNode(n, otherWeights, bias_t'(n * 300 - 700));
		end
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			stimVec[s] = activation_t'(s * 9 - 40);
		end
		repeat (4) idleCycle();
		drainPipe();
	endtask

	task automatic testSaturation();
		weight_t flat [`NN_NUM_INPUTS];
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			flat[s] = 8'sd100;
		end
		writeNode(2, flat, '0);
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			stimVec[s] = 8'sd100;
		end
		idleCycle();
		drainPipe();
		checkResult("results[2]", activation_t'(`NN_SAT_MAX), results[2]);
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			stimVec[s] = -8'sd100;
		end
		idleCycle();
		drainPipe();
		checkResult("results[2]", '0, results[2]);
	endtask

	task automatic testRounding();
		weight_t single [`NN_NUM_INPUTS];
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			single[s] = (s == 0) ? 8'sd1 : 8'sd0;
		end
		writeNode(3, single, '0);
		// 96 is 1.5 after the shift, 95 just under.
		stimVec[0] = 8'sd96;
		idleCycle();
		drainPipe();
		checkResult("results[3]", 8'sd2, results[3]);
		stimVec[0] = 8'sd95;
		idleCycle();
		drainPipe();
		checkResult("results[3]", 8'sd1, results[3]);
	endtask

	task automatic testRandomStream();
		weight_t randWeights [`NN_NUM_INPUTS];
		for (int n = 2; n < `NN_NUM_NODES; n++)
		begin
			for (int s = 0; s < `NN_NUM_INPUTS; s++)
			begin
				randWeights[s] = weight_t'($random(seed) % 32);
			end
			writeNode(n, randWeights, bias_t'($random(seed) % 2048));
		end
		repeat (RandomVectors)
		begin
			for (int s = 0; s < `NN_NUM_INPUTS; s++)
			begin
				stimVec[s] = activation_t'($random(seed));
			end
			idleCycle();
		end
		drainPipe();
	endtask

	task automatic testRewrite();
		for (int s = 0; s < `NN_NUM_INPUTS; s++)
		begin
			stimVec[s] = activation_t'($random(seed) % 24);
		end
		repeat (3) idleCycle();
		runCycle(1'b1, 1, `NN_BIAS_SLOT, 2000);
		repeat (3) idleCycle();
		runCycle(1'b1, 2, 4, 77);
		repeat (3) idleCycle();
		drainPipe();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		cfgWrite = 1'b0;
		cfgAddr = '0;
		cfgData = '0;
		for (int i = 0; i < `NN_NUM_INPUTS; i++)
		begin
			activations[i] = '0;
			stimVec[i] = '0;
		end
		for (int n = 0; n < `NN_NUM_NODES; n++)
		begin
			modelBias[n] = 0;
			for (int s = 0; s < `NN_NUM_INPUTS; s++)
			begin
				modelWeight[n][s] = 0;
			end
		end
		repeat (ResetCycles) @(posedge clk);
		#2;
		reset = 1'b0;

		testReset();
		testReferenceLoad();
		testSaturation();
		testRounding();
		testRandomStream();
		testRewrite();

		$display("errors: %0d compare, %0d assertion", errorCount,
			i_dut.i_checker.assertFails);
		if (errorCount == 0 && i_dut.i_checker.assertFails == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+design
design/nnLayerPkg.sv
design/layerWeightRegs.sv
design/neuronNode.sv
design/nnLayer.sv
tb/nnLayer_checker.sv
tb/nnLayerTb.sv

// File: Bender.yml
package:
  name: nn_layer

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/nnLayerPkg.sv
      - design/layerWeightRegs.sv
      - design/neuronNode.sv
      - design/nnLayer.sv

  - target: test
    include_dirs:
      - design
    files:
      - tb/nnLayer_checker.sv
      - tb/nnLayerTb.sv
